// ==== logic/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width of the stage
`define LSU_XLEN 32

// byte lanes per word
`define LSU_LANES (`LSU_XLEN / 8)

// word address carried on the bus
`define LSU_WADDR (`LSU_XLEN - 2)

// depth of the data RAM in words
`define LSU_RAM_WORDS 1024

// cycles of strobe before the RAM acknowledges
`define LSU_RAM_WAIT 2

`endif

// ==== logic/lsu_pkg.sv ====
`include "lsu_settings.svh"

package lsu_pkg;

    typedef enum logic [5:0] {
        OP_NONE = 6'h00,
        OP_LB   = 6'h20,
        OP_LH   = 6'h21,
        OP_LWL  = 6'h22,
        OP_LW   = 6'h23,
        OP_LBU  = 6'h24,
        OP_LHU  = 6'h25,
        OP_LWR  = 6'h26,
        OP_SB   = 6'h28,
        OP_SH   = 6'h29,
        OP_SWL  = 6'h2a,
        OP_SW   = 6'h2b,
        OP_SWR  = 6'h2e,
        OP_LL   = 6'h30,
        OP_SC   = 6'h38
    } memOp_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } accSize_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUS  = 2'd1,
        RESP = 2'd2
    } busState_e;

    typedef struct packed {
        logic                 valid;
        memOp_e               op;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] storeData;
        logic [`LSU_XLEN-1:0] rtValue;
    } accessReq_t;

    typedef struct packed {
        memOp_e                op;
        logic [`LSU_XLEN-1:0]  addr;
        logic [`LSU_XLEN-1:0]  wdata;     // lanes already placed
        logic [`LSU_LANES-1:0] sel;
        accSize_e              size;
        logic                  isStore;
        logic                  addrError;
        logic [`LSU_XLEN-1:0]  rtValue;   // merge source for lwl/lwr
    } fmtAccess_t;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`LSU_WADDR-1:0] adr;
        logic [`LSU_XLEN-1:0]  dat;
        logic [`LSU_LANES-1:0] sel;
    } wbReq_t;

    typedef struct packed {
        logic                 ack;
        logic [`LSU_XLEN-1:0] dat;
    } wbRsp_t;

    typedef struct packed {
        logic                 valid;
        logic [`LSU_XLEN-1:0] data;
        logic                 addrError;
        accSize_e             size;
    } loadRsp_t;

endpackage

// ==== logic/storeFormat.sv ====
module storeFormat (
    input  lsu_pkg::accessReq_t req,
    output lsu_pkg::fmtAccess_t fmt
);

    logic [1:0] offset;
    logic [4:0] upShift;    // swr moves data toward the msb
    logic [4:0] downShift;  // swl moves data toward the lsb
    logic       wordOp;
    logic       halfOp;

    assign offset    = req.addr[1:0];
    assign upShift   = {offset, 3'b000};
    assign downShift = {~offset, 3'b000};  // 8 * (3 - offset)

    // lane mask and size shared by the load and store of each class
    always_comb begin
        wordOp   = 1'b0;
        halfOp   = 1'b0;
        fmt.sel  = '0;
        fmt.size = lsu_pkg::SIZE_BYTE;
        case (req.op)
            lsu_pkg::OP_SW, lsu_pkg::OP_SC, lsu_pkg::OP_LW, lsu_pkg::OP_LL: begin
                wordOp   = 1'b1;
                fmt.sel  = 4'b1111;
                fmt.size = lsu_pkg::SIZE_WORD;
            end
            lsu_pkg::OP_SH, lsu_pkg::OP_LH, lsu_pkg::OP_LHU: begin
                halfOp   = 1'b1;
                fmt.sel  = offset[1] ? 4'b1100 : 4'b0011;
                fmt.size = lsu_pkg::SIZE_HALF;
            end
            lsu_pkg::OP_SB, lsu_pkg::OP_LB, lsu_pkg::OP_LBU: begin
                fmt.sel  = 4'b0001 << offset;
                fmt.size = lsu_pkg::SIZE_BYTE;
            end
            lsu_pkg::OP_SWL, lsu_pkg::OP_LWL: begin
                fmt.sel  = ~(4'b1110 << offset);  // bytes 0 up to offset
                fmt.size = lsu_pkg::SIZE_WORD;
            end
            lsu_pkg::OP_SWR, lsu_pkg::OP_LWR: begin
                fmt.sel  = 4'b1111 << offset;     // bytes offset up to 3
                fmt.size = lsu_pkg::SIZE_WORD;
            end
            default: begin
                fmt.sel  = '0;
                fmt.size = lsu_pkg::SIZE_BYTE;
            end
        endcase
    end

    // write lanes
    always_comb begin
        fmt.wdata   = '0;
        fmt.isStore = 1'b1;
        case (req.op)
            lsu_pkg::OP_SW, lsu_pkg::OP_SC: begin
                fmt.wdata = req.storeData;
            end
            lsu_pkg::OP_SH: begin
                fmt.wdata = {2{req.storeData[15:0]}};
            end
            lsu_pkg::OP_SB: begin
                fmt.wdata = {4{req.storeData[7:0]}};
            end
            lsu_pkg::OP_SWL: begin
                fmt.wdata = req.storeData >> downShift;
            end
            lsu_pkg::OP_SWR: begin
                fmt.wdata = req.storeData << upShift;
            end
            default: begin
                fmt.isStore = 1'b0;
            end
        endcase
    end

    assign fmt.op        = req.op;
    assign fmt.addr      = req.addr;
    assign fmt.rtValue   = req.rtValue;
    assign fmt.addrError = (wordOp && (offset != 2'b00)) || (halfOp && offset[0]);

endmodule

// ==== logic/loadAlign.sv ====
`include "lsu_settings.svh"

module loadAlign (
    input  lsu_pkg::memOp_e      op,
    input  logic [1:0]           offset,
    input  logic [`LSU_XLEN-1:0] rdata,
    input  logic [`LSU_XLEN-1:0] rtValue,
    output logic [`LSU_XLEN-1:0] data
);

    logic [4:0]           lowShift;
    logic [4:0]           highShift;
    logic [7:0]           byteSel;
    logic [15:0]          halfSel;
    logic [`LSU_XLEN-1:0] lwlKeep;
    logic [`LSU_XLEN-1:0] lwrKeep;

    assign lowShift  = {offset, 3'b000};
    assign highShift = {~offset, 3'b000};   // 8 * (3 - offset)

    assign byteSel = rdata[lowShift +: 8];
    assign halfSel = offset[1] ? rdata[31:16] : rdata[15:0];

    // rt bytes that survive the partial loads
    assign lwlKeep = 32'h00ff_ffff >> lowShift;
    assign lwrKeep = ~(32'hffff_ffff >> lowShift);

    always_comb begin
        case (op)
            lsu_pkg::OP_LW, lsu_pkg::OP_LL: begin
                data = rdata;
            end
            lsu_pkg::OP_LB: begin
                data = {{24{byteSel[7]}}, byteSel};
            end
            lsu_pkg::OP_LBU: begin
                data = {24'b0, byteSel};
            end
            lsu_pkg::OP_LH: begin
                data = {{16{halfSel[15]}}, halfSel};
            end
            lsu_pkg::OP_LHU: begin
                data = {16'b0, halfSel};
            end
            lsu_pkg::OP_LWL: begin
                data = (rdata << highShift) | (rtValue & lwlKeep);  // fills the upper bytes
            end
            lsu_pkg::OP_LWR: begin
                data = (rdata >> lowShift) | (rtValue & lwrKeep);   // fills the lower bytes
            end
            default: begin
                data = '0;
            end
        endcase
    end

endmodule

// ==== logic/wbDataMaster.sv ====
`include "lsu_settings.svh"

module wbDataMaster (
    input  logic                clk,
    input  logic                rstN,
    input  logic                accept,
    input  lsu_pkg::fmtAccess_t fmt,
    output logic                ready,
    input  logic                busy,
    output lsu_pkg::wbReq_t     wbReq,
    input  lsu_pkg::wbRsp_t     wbRsp,
    output lsu_pkg::loadRsp_t   rsp
);

    lsu_pkg::busState_e   state;
    lsu_pkg::fmtAccess_t  acc;
    lsu_pkg::accSize_e    rspSize;
    logic                 linkBit;
    logic                 scFail;
    logic                 skipBus;
    logic                 busCycle;
    logic                 busDone;
    logic                 rspValid;
    logic                 rspError;
    logic [`LSU_XLEN-1:0] rspData;
    logic [`LSU_XLEN-1:0] alignedData;

    assign scFail   = (fmt.op == lsu_pkg::OP_SC) && !linkBit;
    assign skipBus  = fmt.addrError || scFail;  // answered without a bus cycle
    assign busCycle = (state == lsu_pkg::BUS);
    assign busDone  = busCycle && wbRsp.ack;
    assign ready    = (state == lsu_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= lsu_pkg::IDLE;
            linkBit  <= 1'b0;
            rspValid <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::IDLE: begin
                    if (accept) begin
                        state    <= skipBus ? lsu_pkg::RESP : lsu_pkg::BUS;
                        rspValid <= skipBus;
                        if (fmt.op == lsu_pkg::OP_SC) begin
                            linkBit <= 1'b0;  // pass or fail, the link is used up
                        end
                    end
                end
                lsu_pkg::BUS: begin
                    if (wbRsp.ack) begin
                        state    <= lsu_pkg::RESP;
                        rspValid <= 1'b1;
                        if (acc.op == lsu_pkg::OP_LL) begin
                            linkBit <= 1'b1;
                        end
                    end
                end
                lsu_pkg::RESP: begin
                    if (!busy) begin
                        state    <= lsu_pkg::IDLE;
                        rspValid <= 1'b0;
                    end
                end
                default: begin
                    state <= lsu_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc      <= fmt;
            rspData  <= '0;
            rspError <= fmt.addrError;
            rspSize  <= fmt.size;
        end else if (busDone) begin
            rspData <= acc.isStore ? `LSU_XLEN'(acc.op == lsu_pkg::OP_SC) : alignedData;
        end
    end

    loadAlign u_loadAlign (
        .op      (acc.op),
        .offset  (acc.addr[1:0]),
        .rdata   (wbRsp.dat),
        .rtValue (acc.rtValue),
        .data    (alignedData)
    );

    assign wbReq = '{
        cyc: busCycle,
        stb: busCycle,
        we:  busCycle && acc.isStore,
        adr: acc.addr[`LSU_XLEN-1:2],
        dat: acc.wdata,
        sel: acc.sel
    };

    assign rsp = '{valid: rspValid, data: rspData, addrError: rspError, size: rspSize};

endmodule

// ==== logic/dataRam.sv ====
`include "lsu_settings.svh"

module dataRam (
    input  logic            clk,
    input  logic            rstN,
    input  lsu_pkg::wbReq_t wbReq,
    output lsu_pkg::wbRsp_t wbRsp
);

    localparam int IdxW = $clog2(`LSU_RAM_WORDS);
    localparam int CntW = $clog2(`LSU_RAM_WAIT + 2);

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
    logic [IdxW-1:0]      idx;
    logic [CntW-1:0]      waitCnt;
    logic                 strobe;
    logic                 ack;

    assign idx    = wbReq.adr[IdxW-1:0];  // upper address bits fold onto the array
    assign strobe = wbReq.cyc && wbReq.stb;
    assign ack    = strobe && (waitCnt == CntW'(`LSU_RAM_WAIT));

    assign wbRsp = '{ack: ack, dat: mem[idx]};

    initial begin
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // wait states counted from the first strobe cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            waitCnt <= '0;
        end else if (ack) begin
            waitCnt <= '0;
        end else if (strobe) begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    always @(posedge clk) begin
        if (ack && wbReq.we) begin
            for (int lane = 0; lane < `LSU_LANES; lane++) begin
                if (wbReq.sel[lane]) begin
                    mem[idx][8*lane +: 8] <= wbReq.dat[8*lane +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/memStage.sv ====
module memStage (
    input  logic                clk,
    input  logic                rstN,
    input  lsu_pkg::accessReq_t req,
    output logic                ready,
    input  logic                busy,
    output lsu_pkg::loadRsp_t   rsp
);

    lsu_pkg::fmtAccess_t fmt;
    lsu_pkg::wbReq_t     wbReq;
    lsu_pkg::wbRsp_t     wbRsp;
    logic                accept;

    assign accept = req.valid && ready;  // request taken this edge

    storeFormat u_storeFormat (
        .req (req),
        .fmt (fmt)
    );

    wbDataMaster u_wbDataMaster (
        .clk    (clk),
        .rstN   (rstN),
        .accept (accept),
        .fmt    (fmt),
        .ready  (ready),
        .busy   (busy),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .rsp    (rsp)
    );

    dataRam u_dataRam (
        .clk   (clk),
        .rstN  (rstN),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

endmodule

// ==== tests/memStage_assert.sv ====
module memStage_assert (
    input logic                clk,
    input logic                rstN,
    input logic                accept,
    input logic                busy,
    input lsu_pkg::fmtAccess_t fmt,
    input lsu_pkg::wbReq_t     wbReq,
    input lsu_pkg::wbRsp_t     wbRsp,
    input lsu_pkg::loadRsp_t   rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // no response while the bus cycle runs
    stbHasCyc: assert property (@(posedge clk) disable iff (!rstN)
        wbReq.stb |-> wbReq.cyc && !rsp.valid)
    else begin
        failCount++;
        $error("stb high without cyc or during a response");
    end

    // classic cycle holds until the slave answers
    busStable: assert property (@(posedge clk) disable iff (!rstN)
        wbReq.stb && !wbRsp.ack |=> wbReq.stb
            && $stable({wbReq.adr, wbReq.dat, wbReq.sel, wbReq.we}))
    else begin
        failCount++;
        $error("bus request changed before ack");
    end

    ackOnePulse: assert property (@(posedge clk) disable iff (!rstN)
        wbRsp.ack |=> !wbRsp.ack)
    else begin
        failCount++;
        $error("ack held for more than one cycle");
    end

    rspOnePulse: assert property (@(posedge clk) disable iff (!rstN)
        rsp.valid && !busy |=> !rsp.valid)
    else begin
        failCount++;
        $error("rsp.valid held without busy");
    end

    noBusOnError: assert property (@(posedge clk) disable iff (!rstN)
        accept && fmt.addrError |=> !wbReq.cyc)
    else begin
        failCount++;
        $error("bus cycle started for a misaligned access");
    end

endmodule

bind wbDataMaster memStage_assert u_memStageAssert (
    .clk    (clk),
    .rstN   (rstN),
    .accept (accept),
    .busy   (busy),
    .fmt    (fmt),
    .wbReq  (wbReq),
    .wbRsp  (wbRsp),
    .rsp    (rsp)
);

// ==== tests/memStage_tb.sv ====
`include "lsu_settings.svh"

module memStage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                clk;
    logic                rstN;
    logic                busy;
    logic                ready;
    lsu_pkg::accessReq_t req;
    lsu_pkg::loadRsp_t   rsp;

    logic [7:0]  modelMem [256];  // lowest 64 words of the ram
    logic        linkModel;
    logic [31:0] rngState = 32'had84;

    lsu_pkg::memOp_e opList [14] = '{
        lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LWL, lsu_pkg::OP_LW, lsu_pkg::OP_LBU,
        lsu_pkg::OP_LHU, lsu_pkg::OP_LWR, lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SWL,
        lsu_pkg::OP_SW, lsu_pkg::OP_SWR, lsu_pkg::OP_LL, lsu_pkg::OP_SC
    };

    memStage u_memStage (
        .clk   (clk),
        .rstN  (rstN),
        .req   (req),
        .ready (ready),
        .busy  (busy),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function logic [31:0] xorshift32();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic stopWithFailure(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkRsp(input lsu_pkg::loadRsp_t got, input lsu_pkg::loadRsp_t exp,
                            input string what);
        if (got !== exp) begin
            stopWithFailure($sformatf("error %0t: %s rsp %p expected %p", $time, what, got, exp));
        end
    endtask

    task automatic checkReady(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stopWithFailure($sformatf("error %0t: ready %b %s, expected %b", $time, got, what, exp));
        end
    endtask

    task automatic checkValid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stopWithFailure($sformatf("error %0t: rsp.valid %b %s, expected %b", $time, got, what,
                                      exp));
        end
    endtask

    task automatic checkLatency(input int got, input int exp, input string what);
        if (got != exp) begin
            stopWithFailure($sformatf("error %0t: %s answered after %0d cycles, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    // expected response and the store applied to the byte model
    task automatic modelAccess(input lsu_pkg::memOp_e op, input logic [31:0] addr,
                               input logic [31:0] sd, input logic [31:0] rt,
                               output lsu_pkg::loadRsp_t exp, output bit onBus);
        logic [7:0] w [4];
        int         base;
        int         off;
        bit         misaligned;
        base       = int'(addr[7:2]) * 4;
        off        = int'(addr[1:0]);
        misaligned = 1'b0;
        for (int i = 0; i < 4; i++) begin
            w[i] = modelMem[base + i];
        end
        exp       = '0;
        exp.valid = 1'b1;
        case (op)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: begin
                exp.size = lsu_pkg::SIZE_BYTE;
            end
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: begin
                exp.size   = lsu_pkg::SIZE_HALF;
                misaligned = (off % 2) != 0;
            end
            lsu_pkg::OP_LW, lsu_pkg::OP_LL, lsu_pkg::OP_SW, lsu_pkg::OP_SC: begin
                exp.size   = lsu_pkg::SIZE_WORD;
                misaligned = off != 0;
            end
            default: begin
                exp.size = lsu_pkg::SIZE_WORD;  // lwl, lwr, swl, swr
            end
        endcase
        exp.addrError = misaligned;
        onBus = !misaligned && !(op == lsu_pkg::OP_SC && !linkModel);
        if (!misaligned) begin
            case (op)
                lsu_pkg::OP_LB:  exp.data = {{24{w[off][7]}}, w[off]};
                lsu_pkg::OP_LBU: exp.data = {24'h0, w[off]};
                lsu_pkg::OP_LH:  exp.data = {{16{w[off+1][7]}}, w[off+1], w[off]};
                lsu_pkg::OP_LHU: exp.data = {16'h0, w[off+1], w[off]};
                lsu_pkg::OP_LW:  exp.data = {w[3], w[2], w[1], w[0]};
                lsu_pkg::OP_LL: begin
                    exp.data  = {w[3], w[2], w[1], w[0]};
                    linkModel = 1'b1;
                end
                lsu_pkg::OP_LWL: begin
                    exp.data = rt;  // low bytes of rt survive
                    for (int i = 0; i <= off; i++) begin
                        exp.data[8*(3-off+i) +: 8] = w[i];
                    end
                end
                lsu_pkg::OP_LWR: begin
                    exp.data = rt;
                    for (int i = off; i < 4; i++) begin
                        exp.data[8*(i-off) +: 8] = w[i];
                    end
                end
                lsu_pkg::OP_SB: modelMem[base + off] = sd[7:0];
                lsu_pkg::OP_SH: begin
                    modelMem[base + off]     = sd[7:0];
                    modelMem[base + off + 1] = sd[15:8];
                end
                lsu_pkg::OP_SW, lsu_pkg::OP_SC: begin
                    if (op == lsu_pkg::OP_SW || linkModel) begin
                        for (int i = 0; i < 4; i++) begin
                            modelMem[base + i] = sd[8*i +: 8];
                        end
                        exp.data = (op == lsu_pkg::OP_SC) ? 32'd1 : 32'd0;
                    end
                end
                lsu_pkg::OP_SWL: begin
                    for (int i = 0; i <= off; i++) begin
                        modelMem[base + i] = sd[8*(3-off+i) +: 8];  // top bytes of rt
                    end
                end
                lsu_pkg::OP_SWR: begin
                    for (int i = off; i < 4; i++) begin
                        modelMem[base + i] = sd[8*(i-off) +: 8];
                    end
                end
                default: exp.data = '0;
            endcase
        end
        if (op == lsu_pkg::OP_SC) begin
            linkModel = 1'b0;
        end
    endtask

    // one request from handshake to the idle cycle after the response
    task automatic runAccess(input lsu_pkg::memOp_e op, input logic [31:0] addr,
                             input logic [31:0] sd, input logic [31:0] rt, input int stretch);
        lsu_pkg::loadRsp_t exp;
        bit                onBus;
        int                cycles;
        cycles = 0;
        while (!ready) begin
            cycles++;
            if (cycles > 50) begin
                stopWithFailure("timed out after 50 cycles waiting for ready to rise");
            end
            nextCycle();
        end
        modelAccess(op, addr, sd, rt, exp, onBus);
        req = '{valid: 1'b1, op: op, addr: addr, storeData: sd, rtValue: rt};
        nextCycle();
        req.valid = 1'b0;
        busy      = (stretch > 0);
        cycles    = 1;
        while (!rsp.valid) begin
            checkReady(ready, 1'b0, "while the access is running");
            cycles++;
            if (cycles > 50) begin
                stopWithFailure("timed out after 50 cycles waiting for a response");
            end
            nextCycle();
        end
        checkLatency(cycles, onBus ? 2 + `LSU_RAM_WAIT : 1, op.name());
        for (int i = 0; i < stretch; i++) begin
            checkRsp(rsp, exp, "held by busy");
            checkReady(ready, 1'b0, "while busy holds the response");
            nextCycle();
        end
        busy = 1'b0;
        checkRsp(rsp, exp, op.name());
        checkReady(ready, 1'b0, "in the response cycle");
        nextCycle();
        checkValid(rsp.valid, 1'b0, "after the response");
        checkReady(ready, 1'b1, "after the response");
    endtask

    initial begin
        logic [31:0]     r;
        int              stretch;
        lsu_pkg::memOp_e op;
        req       = '0;
        busy      = 1'b0;
        rstN      = 1'b0;
        linkModel = 1'b0;
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = 8'h00;
        end
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;
        checkReady(ready, 1'b1, "after reset");
        checkValid(rsp.valid, 1'b0, "after reset");

        // link pair then a stale sc
        runAccess(lsu_pkg::OP_SW, 32'h40, 32'h1234_5678, 32'h0, 0);
        runAccess(lsu_pkg::OP_LL, 32'h40, 32'h0, 32'h0, 0);
        runAccess(lsu_pkg::OP_SC, 32'h40, 32'hcafe_f00d, 32'h0, 0);
        runAccess(lsu_pkg::OP_SC, 32'h40, 32'h0bad_0bad, 32'h0, 0);
        runAccess(lsu_pkg::OP_LW, 32'h40, 32'h0, 32'h0, 0);
        runAccess(lsu_pkg::OP_SW, 32'h45, 32'hffff_ffff, 32'h0, 0);
        runAccess(lsu_pkg::OP_LW, 32'h44, 32'h0, 32'h0, 0);
        for (int off = 0; off < 4; off++) begin
            runAccess(lsu_pkg::OP_SWL, 32'h80 + off, xorshift32(), 32'h0, 0);
            runAccess(lsu_pkg::OP_LWL, 32'h80 + off, 32'h0, xorshift32(), 0);
            runAccess(lsu_pkg::OP_SWR, 32'h90 + off, xorshift32(), 32'h0, 0);
            runAccess(lsu_pkg::OP_LWR, 32'h90 + off, 32'h0, xorshift32(), 0);
        end

        for (int n = 0; n < 400; n++) begin
            r       = xorshift32();
            op      = opList[r % 14];
            stretch = (r[31:29] == 3'd0) ? int'(r[27:25]) + 1 : 0;
            runAccess(op, xorshift32() & 32'hff, xorshift32(), xorshift32(), stretch);
        end

        if (u_memStage.u_wbDataMaster.u_memStageAssert.failCount != 0) begin
            stopWithFailure("bus assertions failed during the run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/storeFormat.sv
logic/loadAlign.sv
logic/wbDataMaster.sv
logic/dataRam.sv
logic/memStage.sv
tests/memStage_assert.sv
tests/memStage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_pkg.sv
      - logic/storeFormat.sv
      - logic/loadAlign.sv
      - logic/wbDataMaster.sv
      - logic/dataRam.sv
      - logic/memStage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/memStage_assert.sv
      - tests/memStage_tb.sv
